//--- cluster_array.sv
`default_nettype none

`include "decoder_settings.svh"

module cluster_array (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    load,
    input  wire logic [`UF_PU_COUNT-1:0] defects,
    input  wire logic                    grow,
    input  wire logic                    peel,
    output logic                         busy,
    output logic                         odd,
    output logic [`UF_PU_COUNT-1:0]      correction
);

    localparam int N     = `UF_PU_COUNT;
    localparam int RAD_W = $clog2(N + 1);

    logic [N-1:0]     defect_q;
    logic [N-1:0]     cover_q;
    logic [RAD_W-1:0] radius;
    logic             can_grow;
    logic             scan_parity;
    logic             odd_scan;
    logic             peel_open;
    logic [N-1:0]     peel_corr;

    // Coverage stops widening once it spans the whole chain
    assign can_grow = grow && (radius < RAD_W'(N));

    // Parity of each cluster, closed out at the first uncovered PU
    always_comb begin
        scan_parity = 1'b0;
        odd_scan    = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (cover_q[i]) begin
                scan_parity = scan_parity ^ defect_q[i];
            end else begin
                odd_scan    = odd_scan | scan_parity;
                scan_parity = 1'b0;
            end
        end
    end

    // Pair defects left to right; an open pair at PU 7 runs to the boundary
    always_comb begin
        peel_open = 1'b0;
        for (int i = 0; i < N; i++) begin
            if (!cover_q[i]) begin
                peel_open = 1'b0;
            end else if (defect_q[i]) begin
                peel_open = !peel_open;
            end
            peel_corr[i] = peel_open;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy   <= 1'b0;
            odd    <= 1'b0;
            radius <= '0;
        end else begin
            busy <= grow || peel;
            if (load) begin
                radius <= '0;
                odd    <= 1'b0;
            end else begin
                if (can_grow) begin
                    radius <= radius + 1'b1;
                end
                if (busy) begin
                    odd <= odd_scan;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            defect_q <= defects;
            cover_q  <= defects;
        end else if (can_grow) begin
            cover_q <= cover_q | (cover_q << 1) | (cover_q >> 1);
        end
        if (peel) begin
            correction <= peel_corr;
        end
    end

endmodule

`default_nettype wire

//--- decoder_pkg.sv
`default_nettype none

`include "decoder_settings.svh"

package decoder_pkg;

    typedef enum logic [2:0] {
        IDLE,
        PARAMS,
        MEAS_PREPARING,
        MEAS_LOADING,
        GROW,
        MERGE,
        PEELING,
        RESULT
    } stage_e;

    typedef enum logic [7:0] {
        MSG_START       = 8'h01,
        MSG_MEAS_HEADER = 8'h02
    } msg_e;

    typedef struct packed {
        logic [7:0]              iterations;
        logic [15:0]             cycles;
        logic [`UF_PU_COUNT-1:0] correction; // Bit 7 is the right boundary edge
    } result_t;

endpackage

`default_nettype wire

//--- decoder_settings.svh
`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// Processing units in the chain
// This is also the width of the measurement byte and of the correction
`define UF_PU_COUNT 8

// Extra cycles that MERGE and PEELING wait before they sample busy
`define UF_STAGE_DELAY 2

// Result records buffered ahead of the serializer
`define UF_FIFO_DEPTH 4

`endif

//--- filelist.f
+incdir+.
decoder_pkg.sv
stage_controller.sv
cluster_array.sv
result_fifo.sv
result_serializer.sv
uf_decoder_top.sv
uf_decoder_chk.sv
uf_decoder_tb.sv

//--- result_fifo.sv
`default_nettype none

`include "decoder_settings.svh"

module result_fifo
    import decoder_pkg::*;
#(
    parameter int DEPTH = `UF_FIFO_DEPTH
) (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire result_t push_data,
    input  wire logic    push_valid,
    output logic         push_ready,
    output result_t      pop_data,
    output logic         pop_valid,
    input  wire logic    pop_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    result_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push_fire;
    logic             pop_fire;

    assign push_ready = (count != CNT_W'(DEPTH));
    assign pop_valid  = (count != '0);
    assign pop_data   = mem[rd_ptr];
    assign push_fire  = push_valid && push_ready;
    assign pop_fire   = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count <= count + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

//--- result_serializer.sv
`default_nettype none

module result_serializer
    import decoder_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire result_t pop_data,
    input  wire logic    pop_valid,
    output logic         pop_ready,
    output logic [7:0]   out_data,
    output logic         out_valid,
    input  wire logic    out_ready
);

    result_t    record;
    logic [1:0] byte_idx;
    logic       out_fire;
    logic       last_byte;

    assign out_fire  = out_valid && out_ready;
    assign last_byte = (byte_idx == 2'd3);

    // Take the next record while the last byte of the current one leaves
    assign pop_ready = pop_valid && (!out_valid || (out_fire && last_byte));

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            byte_idx  <= '0;
        end else if (pop_ready) begin
            out_valid <= 1'b1;
            byte_idx  <= '0;
        end else if (out_fire) begin
            if (last_byte) begin
                out_valid <= 1'b0;
            end
            byte_idx <= byte_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pop_ready) begin
            record <= pop_data;
        end
    end

    always_comb begin
        case (byte_idx)
            2'd0:    out_data = record.iterations;
            2'd1:    out_data = record.cycles[15:8];
            2'd2:    out_data = record.cycles[7:0];
            default: out_data = record.correction;
        endcase
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module uf_decoder_tb \
    -f filelist.f -o sim_uf_decoder > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim_uf_decoder > sim.log 2>&1 || echo "Simulator returned an error status"
grep -q "TB FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation did not complete, see sim.log"; exit 1; }
echo "Simulation passed"

//--- stage_controller.sv
`default_nettype none

`include "decoder_settings.svh"

module stage_controller
    import decoder_pkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic [7:0]              in_data,
    input  wire logic                    in_valid,
    output logic                         in_ready,
    output logic [`UF_PU_COUNT-1:0]      defects,
    output logic                         load,
    output logic                         grow,
    output logic                         peel,
    input  wire logic                    busy,
    input  wire logic                    odd,
    input  wire logic [`UF_PU_COUNT-1:0] correction,
    output result_t                      push_data,
    output logic                         push_valid,
    input  wire logic                    push_ready,
    output stage_e                       stage
);

    localparam int DELAY_W = $clog2(`UF_STAGE_DELAY + 1);

    stage_e             stage_next;
    logic [DELAY_W-1:0] delay_cnt;
    logic [7:0]         iter_cnt;
    logic [15:0]        cycle_cnt;
    logic               in_fire;
    logic               delay_done;

    assign in_fire    = in_valid && in_ready;
    assign delay_done = (delay_cnt >= DELAY_W'(`UF_STAGE_DELAY));

    always_comb begin
        stage_next = stage;
        case (stage)
            IDLE: begin
                if (in_fire) begin
                    if (in_data == MSG_START) begin
                        stage_next = PARAMS;
                    end else if (in_data == MSG_MEAS_HEADER) begin
                        stage_next = MEAS_PREPARING;
                    end
                end
            end
            PARAMS:         stage_next = IDLE;
            MEAS_PREPARING: begin
                if (in_fire) begin
                    stage_next = MEAS_LOADING;
                end
            end
            MEAS_LOADING:   stage_next = GROW;
            GROW:           stage_next = MERGE;
            MERGE: begin
                if (delay_done && !busy) begin
                    stage_next = odd ? GROW : PEELING;
                end
            end
            PEELING: begin
                if (delay_done && !busy) begin
                    stage_next = RESULT;
                end
            end
            RESULT: begin
                if (push_ready) begin
                    stage_next = IDLE; // Full FIFO holds us here
                end
            end
            default:        stage_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage      <= IDLE;
            delay_cnt  <= '0;
            in_ready   <= 1'b0;
            push_valid <= 1'b0;
        end else begin
            stage      <= stage_next;
            in_ready   <= (stage_next == IDLE) || (stage_next == MEAS_PREPARING);
            push_valid <= (stage_next == RESULT);
            if (stage_next != stage) begin
                delay_cnt <= '0;
            end else if (!delay_done) begin
                delay_cnt <= delay_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            iter_cnt  <= '0;
            cycle_cnt <= '0;
        end else if (stage == PARAMS) begin
            iter_cnt  <= '0;
            cycle_cnt <= '0;
        end else if (stage == MEAS_LOADING) begin
            iter_cnt  <= '0;
            cycle_cnt <= 16'd1;
        end else begin
            if (stage == GROW) begin
                iter_cnt <= iter_cnt + 1'b1;
            end
            if (stage inside {GROW, MERGE, PEELING}) begin
                cycle_cnt <= cycle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stage == MEAS_PREPARING && in_fire) begin
            defects <= in_data;
        end
    end

    assign load = (stage == MEAS_LOADING);
    assign grow = (stage == GROW);
    assign peel = (stage == PEELING) && (delay_cnt == '0); // First PEELING cycle only

    assign push_data = '{iterations: iter_cnt, cycles: cycle_cnt, correction: correction};

endmodule

`default_nettype wire

//--- uf_decoder_chk.sv
`default_nettype none

module uf_decoder_chk
    import decoder_pkg::*;
(
    input wire logic       clk,
    input wire logic       reset,
    input wire stage_e     stage,
    input wire logic       in_ready,
    input wire logic       push_valid,
    input wire logic       busy,
    input wire logic       out_valid,
    input wire logic [7:0] out_data,
    input wire logic       out_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    a_in_ready_stage: assert property (@(posedge clk) disable iff (reset)
        in_ready |-> (stage == IDLE || stage == MEAS_PREPARING))
        else $error("in_ready high outside IDLE and MEAS_PREPARING");

    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
        else $error("Output byte changed or dropped while stalled");

    a_push_in_result: assert property (@(posedge clk) disable iff (reset)
        push_valid |-> (stage == RESULT))
        else $error("push_valid high outside RESULT");

    a_merge_busy: assert property (@(posedge clk) disable iff (reset)
        (stage == MERGE && busy) |=> (stage == MERGE))
        else $error("MERGE left while the array was busy");

endmodule

bind stage_controller uf_decoder_chk i_ctrl_chk (
    .clk        (clk),
    .reset      (reset),
    .stage      (stage),
    .in_ready   (in_ready),
    .push_valid (push_valid),
    .busy       (busy),
    .out_valid  (1'b0),      // No output stream here
    .out_data   (8'h00),
    .out_ready  (1'b1)
);

bind result_serializer uf_decoder_chk i_ser_chk (
    .clk        (clk),
    .reset      (reset),
    .stage      (decoder_pkg::IDLE),
    .in_ready   (1'b0),
    .push_valid (1'b0),
    .busy       (1'b0),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready)
);

`default_nettype wire

//--- uf_decoder_tb.sv
`default_nettype none

`include "decoder_settings.svh"

module uf_decoder_tb
    import decoder_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N          = `UF_PU_COUNT;
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;
    localparam int NUM_TESTS  = 219; // 6 directed, 200 random, 12 back-pressure, 1 after junk

    logic       clk;
    logic       reset;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_ready;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_ready;

    result_t exp_q[$];
    string   name_q[$];
    int      errors;
    int      checks;
    int      bp_mode;      // 0 ready, 1 random, 2 held low
    int      stall_cycles;
    bit      stall_seen;

    uf_decoder_top i_dut (
        .clk       (clk),
        .reset     (reset),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // PUs within distance k of a defect
    function automatic logic [N-1:0] cover_at(input logic [N-1:0] d, input int k);
        logic [N-1:0] c;
        c = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < N; j++) begin
                if (d[j] && (i - j <= k) && (j - i <= k)) begin
                    c[i] = 1'b1;
                end
            end
        end
        return c;
    endfunction

    // Pairs defects cluster by cluster and flags a leftover away from the boundary
    function automatic logic [N-1:0] peel_ref(input logic [N-1:0] d, input logic [N-1:0] cov,
                                              output bit odd_left);
        logic [N-1:0] corr;
        int           i;
        int           open;
        corr     = '0;
        odd_left = 1'b0;
        i        = 0;
        while (i < N) begin
            if (cov[i]) begin
                open = -1;
                while (i < N && cov[i]) begin
                    if (d[i] && open < 0) begin
                        open = i;
                    end else if (d[i]) begin
                        for (int e = open; e < i; e++) begin
                            corr[e] = 1'b1;
                        end
                        open = -1;
                    end
                    i++;
                end
                if (open >= 0 && i == N) begin
                    for (int e = open; e < N; e++) begin
                        corr[e] = 1'b1; // Out to the right boundary
                    end
                end else if (open >= 0) begin
                    odd_left = 1'b1;
                end
            end else begin
                i++;
            end
        end
        return corr;
    endfunction

    function automatic result_t decode_ref(input logic [N-1:0] d);
        result_t      r;
        logic [N-1:0] corr;
        bit           odd_left;
        int           k;
        k        = 0;
        odd_left = 1'b1;
        while (odd_left) begin
            k++;
            corr = peel_ref(d, cover_at(d, k), odd_left);
        end
        r.iterations = 8'(k);
        r.cycles     = 16'(1 + 4 * k + 3);
        r.correction = corr;
        return r;
    endfunction

    task automatic send_byte(input logic [7:0] b);
        in_data  = b;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    task automatic send_meas(input logic [7:0] d, input string tname);
        exp_q.push_back(decode_ref(d));
        name_q.push_back(tname);
        send_byte(MSG_MEAS_HEADER);
        send_byte(d);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(posedge clk);
        repeat (10) @(posedge clk); // Room for any stray byte
        #DRIVE_DLY;
    endtask

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DLY;
            if (bp_mode == 0) begin
                out_ready = 1'b1;
            end else if (bp_mode == 1) begin
                out_ready = ($urandom % 3 == 0);
            end else begin
                out_ready = 1'b0;
            end
        end
    end

    initial begin
        stall_cycles = 0;
        stall_seen   = 1'b0;
        forever begin
            @(negedge clk);
            if (in_valid && !in_ready) begin
                stall_cycles++;
            end else begin
                stall_cycles = 0;
            end
            if (stall_cycles >= 64) begin
                stall_seen = 1'b1; // Longer than any single decode
            end
        end
    end

    initial begin : receiver
        result_t got;
        result_t exp;
        string   tname;
        int      idx;
        idx = 0;
        got = '0;
        forever begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                got = {got[23:0], out_data};
                idx++;
                if (idx == 4) begin
                    idx = 0;
                    if (exp_q.size() == 0) begin
                        $display("ERROR: output record %h arrived with no decode pending", got);
                        errors++;
                    end else begin
                        exp   = exp_q.pop_front();
                        tname = name_q.pop_front();
                        checks++;
                        assert (got == exp) else begin
                            $display("CHECK FAILED: %s expected %h actual %h", tname, exp, got);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin
        #(NUM_TESTS * 60 * CLK_PERIOD);
        $display("ERROR: timeout, the run did not finish within %0d ns",
                 NUM_TESTS * 60 * CLK_PERIOD);
        $display("TB FAILED");
        $finish;
    end

    initial begin : main
        int r;
        errors   = 0;
        checks   = 0;
        bp_mode  = 0;
        void'($urandom(32'ha1e7_07f0));
        reset    = 1'b1;
        in_valid = 1'b0;
        in_data  = 8'h00;
        repeat (4) @(posedge clk);
        #DRIVE_DLY;
        reset = 1'b0;
        @(posedge clk);
        @(negedge clk);
        assert (in_ready && !out_valid) else begin
            $display("CHECK FAILED: after_reset expected in_ready=1 out_valid=0 actual %b %b",
                     in_ready, out_valid);
            errors++;
        end
        @(posedge clk);
        #DRIVE_DLY;

        send_meas(8'h00, "no_defects");
        send_meas(8'h10, "one_defect");
        send_meas(8'h18, "adjacent_pair");
        send_meas(8'h81, "far_pair");
        send_meas(8'h25, "three_defects");
        send_meas(8'hFF, "all_defects");
        wait_drain();

        for (int i = 0; i < 200; i++) begin
            r = $urandom % 8;
            if (r == 0) begin
                send_byte(MSG_START);
            end else if (r == 1) begin
                send_byte(8'hA0 | 8'($urandom % 16)); // Never a valid opcode
            end
            send_meas(8'($urandom), $sformatf("random_%0d", i));
        end
        wait_drain();

        bp_mode = 2;
        fork
            begin
                for (int i = 0; i < 12; i++) begin
                    send_meas(8'($urandom), $sformatf("backpressure_%0d", i));
                end
            end
            begin
                for (int c = 0; c < 600 && !stall_seen; c++) begin
                    @(posedge clk);
                end
                bp_mode = 1;
            end
        join
        wait_drain();
        bp_mode = 0;
        assert (stall_seen) else begin
            $display("ERROR: in_ready never stalled while the output was held off");
            errors++;
        end

        send_byte(MSG_START);
        send_byte(8'h7E);
        send_byte(8'hFF);
        repeat (20) @(posedge clk);
        #DRIVE_DLY;
        send_meas(8'h42, "after_start_junk");
        wait_drain();

        $display("Records checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uf_decoder_top.sv
`default_nettype none

`include "decoder_settings.svh"

module uf_decoder_top
    import decoder_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire logic [7:0] in_data,
    input  wire logic       in_valid,
    output logic            in_ready,
    output logic [7:0]      out_data,
    output logic            out_valid,
    input  wire logic       out_ready
);

    logic [`UF_PU_COUNT-1:0] defects;
    logic                    load;
    logic                    grow;
    logic                    peel;
    logic                    busy;
    logic                    odd;
    logic [`UF_PU_COUNT-1:0] correction;
    result_t                 push_data;
    logic                    push_valid;
    logic                    push_ready;
    result_t                 pop_data;
    logic                    pop_valid;
    logic                    pop_ready;

    stage_controller u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .defects    (defects),
        .load       (load),
        .grow       (grow),
        .peel       (peel),
        .busy       (busy),
        .odd        (odd),
        .correction (correction),
        .push_data  (push_data),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .stage      ()            // Observed by the bound checker
    );

    cluster_array u_array (
        .clk        (clk),
        .reset      (reset),
        .load       (load),
        .defects    (defects),
        .grow       (grow),
        .peel       (peel),
        .busy       (busy),
        .odd        (odd),
        .correction (correction)
    );

    result_fifo #(
        .DEPTH (`UF_FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push_data  (push_data),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .pop_data   (pop_data),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready)
    );

    result_serializer u_ser (
        .clk        (clk),
        .reset      (reset),
        .pop_data   (pop_data),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire
